// ==== logic/bus_pkg.sv ====
package bus_pkg;

    // Bus words carry whole registers
    typedef isa_pkg::xword_t bus_word_t;

    typedef enum logic [1:0] {
        OKAY   = 2'd0,
        SLVERR = 2'd2
    } resp_t;

    ////////////////////
    // Address map

    // Instructions are written here
    localparam int ISSUE_ADDR = 0;

    // Register n is read at byte address n*8
    localparam int REG_WINDOW_SHIFT = 3;

endpackage

// ==== logic/decode_stage.sv ====
module decode_stage import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     issue_valid,
    input  instr_t   issue_instr,
    output logic     illegal,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  xword_t   rs1_val,      // Already bypassed for the writeback edge
    input  xword_t   rs2_val,
    input  logic     ex_valid,
    input  reg_idx_t ex_rd,
    input  xword_t   ex_result,
    output logic     dec_valid,
    output alu_op_t  dec_op,
    output xword_t   dec_a,
    output xword_t   dec_b,
    output reg_idx_t dec_rd
);
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic [5:0] funct6;
    reg_idx_t   rd;
    xword_t     imm_i;
    xword_t     imm_u;
    alu_op_t    op;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       ex_hit1;
    logic       ex_hit2;
    logic       a_late;
    logic       b_late;
    xword_t     op_a;
    xword_t     op_b;
    xword_t     a_q;
    xword_t     b_q;
    logic       a_late_q;
    logic       b_late_q;

    ////////////////////
    // Fields and immediates

    assign opcode  = issue_instr[6:0];
    assign rd      = issue_instr[11:7];
    assign funct3  = issue_instr[14:12];
    assign rs1_idx = issue_instr[19:15];
    assign rs2_idx = issue_instr[24:20];
    assign funct7  = issue_instr[31:25];
    assign funct6  = issue_instr[31:26];

    assign imm_i = {{(XLEN-12){issue_instr[31]}}, issue_instr[31:20]};
    assign imm_u = {{(XLEN-32){issue_instr[31]}}, issue_instr[31:12], 12'b0};

    always_comb begin
        case (funct3)
            F3_ADD:  op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
            F3_SLL:  op = ALU_SLL;
            F3_SLT:  op = ALU_SLT;
            F3_SLTU: op = ALU_SLTU;
            F3_XOR:  op = ALU_XOR;
            F3_SR:   op = funct7[5] ? ALU_SRA : ALU_SRL;
            F3_OR:   op = ALU_OR;
            F3_AND:  op = ALU_AND;
        endcase
        if (opcode == OPC_LUI) begin
            op = ALU_PASS_B;
        end
    end

    always_comb begin
        case (opcode)
            OPC_OP: begin
                if (funct7 == F7_ALT) begin
                    illegal = (funct3 != F3_ADD) && (funct3 != F3_SR);
                end else begin
                    illegal = funct7 != F7_BASE;
                end
            end
            OPC_OP_IMM: begin
                // shamt[5] sits in bit 25 so only funct6 is checked
                if (funct3 == F3_SLL) begin
                    illegal = funct6 != F6_BASE;
                end else if (funct3 == F3_SR) begin
                    illegal = (funct6 != F6_BASE) && (funct6 != F6_ALT);
                end else begin
                    illegal = 1'b0;
                end
            end
            OPC_LUI: illegal = 1'b0;
            default: illegal = 1'b1;
        endcase
    end

    ////////////////////
    // Operand selection

    assign uses_rs1 = opcode != OPC_LUI;
    assign uses_rs2 = opcode == OPC_OP;

    assign ex_hit1 = ex_valid && (ex_rd != '0) && (ex_rd == rs1_idx);
    assign ex_hit2 = ex_valid && (ex_rd != '0) && (ex_rd == rs2_idx);

    // Producer still in the decode register has no result yet
    assign a_late = uses_rs1 && dec_valid && (dec_rd != '0) && (dec_rd == rs1_idx);
    assign b_late = uses_rs2 && dec_valid && (dec_rd != '0) && (dec_rd == rs2_idx);

    assign op_a = !uses_rs1 ? '0 : (ex_hit1 ? ex_result : rs1_val);

    always_comb begin
        if (uses_rs2) begin
            op_b = ex_hit2 ? ex_result : rs2_val;
        end else if (opcode == OPC_LUI) begin
            op_b = imm_u;
        end else begin
            op_b = imm_i;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= issue_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid) begin
            dec_op   <= op;
            dec_rd   <= rd;
            a_q      <= op_a;
            b_q      <= op_b;
            a_late_q <= a_late;
            b_late_q <= b_late;
        end
    end

    // By now that producer sits in the execute register
    assign dec_a = a_late_q ? ex_result : a_q;
    assign dec_b = b_late_q ? ex_result : b_q;

    // The bus port filters illegal encodings before issue
    no_illegal_issue: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> !illegal);

endmodule

// ==== logic/execute_stage.sv ====
module execute_stage import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     dec_valid,
    input  alu_op_t  dec_op,
    input  xword_t   dec_a,
    input  xword_t   dec_b,
    input  reg_idx_t dec_rd,
    output logic     ex_valid,
    output xword_t   ex_result,
    output reg_idx_t ex_rd
);
    shamt_t shamt;
    logic   sh_left;
    logic   sh_fill;
    xword_t sh_in;
    xword_t sh_stage;
    xword_t sh_out;
    xword_t alu_out;

    function automatic xword_t bit_reverse(input xword_t v);
        xword_t r;
        for (int i = 0; i < XLEN; i++) begin
            r[i] = v[XLEN-1-i];
        end
        return r;
    endfunction

    ////////////////////
    // Barrel shifter

    assign shamt   = dec_b[$bits(shamt_t)-1:0];
    assign sh_left = dec_op == ALU_SLL;
    assign sh_fill = (dec_op == ALU_SRA) && dec_a[XLEN-1];    // Sign fill for SRA only

    // SLL runs on the bit-reversed word
    assign sh_in = sh_left ? bit_reverse(dec_a) : dec_a;

    always_comb begin
        sh_stage = sh_in;
        for (int i = 0; i < $bits(shamt_t); i++) begin
            if (shamt[i]) begin
                sh_stage = (sh_stage >> (1 << i))
                         | ({XLEN{sh_fill}} & ~({XLEN{1'b1}} >> (1 << i)));
            end
        end
    end

    assign sh_out = sh_left ? bit_reverse(sh_stage) : sh_stage;

    ////////////////////
    // ALU

    always_comb begin
        case (dec_op)
            ALU_ADD:    alu_out = dec_a + dec_b;
            ALU_SUB:    alu_out = dec_a - dec_b;
            ALU_SLL:    alu_out = sh_out;
            ALU_SRL:    alu_out = sh_out;
            ALU_SRA:    alu_out = sh_out;
            ALU_SLT:    alu_out = xword_t'($signed(dec_a) < $signed(dec_b));
            ALU_SLTU:   alu_out = xword_t'(dec_a < dec_b);
            ALU_XOR:    alu_out = dec_a ^ dec_b;
            ALU_OR:     alu_out = dec_a | dec_b;
            ALU_AND:    alu_out = dec_a & dec_b;
            ALU_PASS_B: alu_out = dec_b;
            default:    alu_out = '0;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid) begin
            ex_result <= alu_out;
            ex_rd     <= dec_rd;    // x0 still flows, writeback drops it
        end
    end

endmodule

// ==== logic/host_port.sv ====
module host_port import bus_pkg::*, isa_pkg::*; #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [ADDR_WIDTH-1:0]          awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  bus_word_t                      wdata,
    input  logic [$bits(bus_word_t)/8-1:0] wstrb,      // Unused since instructions are whole
    output logic                           bvalid,
    input  logic                           bready,
    output resp_t                          bresp,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [ADDR_WIDTH-1:0]          araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output bus_word_t                      rdata,
    output resp_t                          rresp,
    input  logic                           illegal,    // From decode, for issue_instr
    input  logic                           dec_valid,
    input  logic                           ex_valid,
    input  xword_t                         host_val,
    output logic                           issue_valid,
    output instr_t                         issue_instr,
    output reg_idx_t                       host_idx
);
    localparam int WINDOW_BYTES = NUM_REGS << REG_WINDOW_SHIFT;

    logic wr_accept;
    logic wr_addr_ok;
    logic rd_accept;
    logic rd_in_window;

    ////////////////////
    // Write channel

    assign awready = !bvalid || bready;    // Free again once the response is taken
    assign wready  = awready;

    assign wr_accept   = awvalid && wvalid && awready && wready;
    assign wr_addr_ok  = awaddr == ADDR_WIDTH'(ISSUE_ADDR);
    assign issue_instr = wdata[$bits(instr_t)-1:0];

    // Bad address or encoding gets SLVERR and never reaches decode
    assign issue_valid = wr_accept && wr_addr_ok && !illegal;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_accept) begin
            bvalid <= 1'b1;
        end else if (bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= issue_valid ? OKAY : SLVERR;
        end
    end

    ////////////////////
    // Read channel

    // Wait for the pipeline to drain so the read sees every earlier write
    assign arready = !rvalid && !dec_valid && !ex_valid;

    assign rd_accept    = arvalid && arready;
    assign rd_in_window = araddr < WINDOW_BYTES;
    assign host_idx     = araddr[REG_WINDOW_SHIFT +: $bits(reg_idx_t)];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_accept) begin
            rvalid <= 1'b1;
        end else if (rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_in_window ? host_val : '0;
            rresp <= rd_in_window ? OKAY : SLVERR;
        end
    end

    // A pending write response stays put until the host takes it
    bresp_held: assert property (@(posedge clk) disable iff (rst)
        bvalid && !bready |=> bvalid && $stable(bresp));

endmodule

// ==== logic/isa_pkg.sv ====
package isa_pkg;

    localparam int XLEN     = 64;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] xword_t;
    typedef logic [31:0]     instr_t;
    typedef logic [4:0]      reg_idx_t;
    typedef logic [5:0]      shamt_t;    // RV64 shifts use six bits

    ////////////////////
    // Major opcodes accepted by the unit

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    ////////////////////
    // Function fields

    localparam logic [2:0] F3_ADD  = 3'b000;    // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;    // SRL and SRA share it
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;    // SUB and SRA
    localparam logic [5:0] F6_BASE = 6'b000000;     // Immediate shifts
    localparam logic [5:0] F6_ALT  = 6'b010000;     // SRAI

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // LUI
    } alu_op_t;

endpackage

// ==== logic/rv64_exec_unit.sv ====
module rv64_exec_unit import bus_pkg::*, isa_pkg::*; #(
    parameter int ADDR_WIDTH = 12
) (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           awvalid,
    output logic                           awready,
    input  logic [ADDR_WIDTH-1:0]          awaddr,
    input  logic                           wvalid,
    output logic                           wready,
    input  bus_word_t                      wdata,
    input  logic [$bits(bus_word_t)/8-1:0] wstrb,
    output logic                           bvalid,
    input  logic                           bready,
    output resp_t                          bresp,
    input  logic                           arvalid,
    output logic                           arready,
    input  logic [ADDR_WIDTH-1:0]          araddr,
    output logic                           rvalid,
    input  logic                           rready,
    output bus_word_t                      rdata,
    output resp_t                          rresp
);
    // Issue path
    logic     issue_valid;
    instr_t   issue_instr;
    logic     illegal;

    // Decode to execute
    logic     dec_valid;
    alu_op_t  dec_op;
    xword_t   dec_a;
    xword_t   dec_b;
    reg_idx_t dec_rd;

    // Execute result, also forwarded to decode
    logic     ex_valid;
    xword_t   ex_result;
    reg_idx_t ex_rd;

    // Register file ports
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    xword_t   rs1_val;
    xword_t   rs2_val;
    reg_idx_t host_idx;
    xword_t   host_val;

    ////////////////////
    // Bus port and pipeline

    host_port #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_host_port (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    writeback_stage u_writeback (.*);

endmodule

// ==== logic/writeback_stage.sv ====
module writeback_stage import isa_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     ex_valid,
    input  reg_idx_t ex_rd,
    input  xword_t   ex_result,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t host_idx,
    output xword_t   rs1_val,
    output xword_t   rs2_val,
    output xword_t   host_val
);
    xword_t regs [NUM_REGS];
    logic   wr_en;

    assign wr_en = ex_valid && (ex_rd != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex_rd] <= ex_result;
        end
    end

    ////////////////////
    // Read ports

    // Operand reads see the write landing on this edge
    assign rs1_val = (rs1_idx == '0) ? '0 :
                     (ex_valid && ex_rd == rs1_idx) ? ex_result : regs[rs1_idx];
    assign rs2_val = (rs2_idx == '0) ? '0 :
                     (ex_valid && ex_rd == rs2_idx) ? ex_result : regs[rs2_idx];

    // Host reads only start on an empty pipeline
    assign host_val = regs[host_idx];

    x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
        regs[0] == '0);

endmodule

// ==== rv64_exec_unit.f ====
logic/isa_pkg.sv
logic/bus_pkg.sv
logic/host_port.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/writeback_stage.sv
logic/rv64_exec_unit.sv
test/rv64_exec_unit_tb.sv

// ==== test/rv64_exec_unit_tb.sv ====
module rv64_exec_unit_tb import bus_pkg::*, isa_pkg::*; ();
    localparam int ADDR_WIDTH = 12;
    localparam int NUM_TESTS  = 6;

    logic clk, rst;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [ADDR_WIDTH-1:0] awaddr, araddr;
    logic [$bits(bus_word_t)/8-1:0] wstrb;
    bus_word_t wdata, rdata;
    resp_t bresp, rresp;

    xword_t model_regs [NUM_REGS];    // Expected register file
    int seed = 32'hd772de57;
    int value_errors, resp_errors, protocol_errors;

    rv64_exec_unit #(.ADDR_WIDTH(ADDR_WIDTH)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(NUM_TESTS * 2000);
        $display("Timeout: the tests did not finish within %0d time units", NUM_TESTS * 2000);
        $display("Verification failed");
        $finish;
    end

    ////////////////////
    // Encoding and reference model

    function automatic instr_t r_type(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic instr_t i_type(logic [11:0] imm, logic [2:0] f3, reg_idx_t rd, rs1);
        return {imm, rs1, f3, rd, OPC_OP_IMM};
    endfunction

    function automatic instr_t lui(reg_idx_t rd, logic [19:0] imm);
        return {imm, rd, OPC_LUI};
    endfunction

    function automatic xword_t rand_word();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic xword_t model_result(instr_t ins);
        xword_t a;
        xword_t b;
        logic [5:0] sh;
        a  = model_regs[ins[19:15]];
        b  = (ins[6:0] == OPC_OP) ? model_regs[ins[24:20]] : {{52{ins[31]}}, ins[31:20]};
        sh = b[5:0];    // RV64 shift amount
        if (ins[6:0] == OPC_LUI) return {{32{ins[31]}}, ins[31:12], 12'b0};
        case (ins[14:12])
            F3_ADD:  return (ins[6:0] == OPC_OP && ins[30]) ? a - b : a + b;
            F3_SLL:  return a << sh;
            F3_SLT:  return ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            F3_SLTU: return (a < b) ? 64'd1 : 64'd0;
            F3_XOR:  return a ^ b;
            F3_SR:   return ins[30] ? xword_t'($signed(a) >>> sh) : a >> sh;
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic void model_commit(instr_t ins);
        if (ins[11:7] != 5'd0) model_regs[ins[11:7]] = model_result(ins);
    endfunction

    ////////////////////
    // Compare tasks

    task automatic check_word(xword_t got, xword_t exp, string what);
        if (got !== exp) begin
            value_errors++;
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_resp(resp_t got, resp_t exp, string what);
        if (got !== exp) begin
            resp_errors++;
            $display("Fail at %0t: %s gave %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic protocol_error(string what);
        protocol_errors++;
        $display("Error at %0t: %s", $time, what);
    endtask

    ////////////////////
    // Bus tasks

    task automatic axi_write(logic [ADDR_WIDTH-1:0] addr, instr_t ins, output resp_t resp);
        @(posedge clk);
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= addr;
        wdata   <= bus_word_t'(ins);
        @(negedge clk);
        while (!(awready && wready)) @(negedge clk);
        @(posedge clk);                     // Handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
    endtask

    task automatic axi_read(logic [ADDR_WIDTH-1:0] addr, output xword_t data, output resp_t resp);
        @(posedge clk);
        arvalid <= 1'b1;
        araddr  <= addr;
        @(negedge clk);
        while (!arready) @(negedge clk);    // Pipeline drains first
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
    endtask

    task automatic run(instr_t ins);
        resp_t r;
        axi_write(ADDR_WIDTH'(ISSUE_ADDR), ins, r);
        check_resp(r, OKAY, $sformatf("issue of %h", ins));
        model_commit(ins);
    endtask

    task automatic expect_reject(logic [ADDR_WIDTH-1:0] addr, instr_t ins);
        resp_t r;
        axi_write(addr, ins, r);
        check_resp(r, SLVERR, $sformatf("rejected write of %h", ins));
    endtask

    task automatic check_reg(reg_idx_t idx);
        xword_t d;
        resp_t r;
        axi_read(ADDR_WIDTH'(idx) << REG_WINDOW_SHIFT, d, r);
        check_resp(r, OKAY, $sformatf("read of x%0d", idx));
        check_word(d, model_regs[idx], $sformatf("x%0d", idx));
    endtask

    // LUI, SRAI, then ORI chunks of 11 bits moved up by SLLI
    task automatic load_reg(reg_idx_t rd, xword_t v);
        run(lui(rd, v[63:44]));
        run(i_type({F6_ALT, 6'd1}, F3_SR, rd, rd));
        run(i_type({1'b0, v[43:33]}, F3_OR, rd, rd));
        for (int k = 2; k >= 0; k--) begin
            run(i_type({F6_BASE, 6'd11}, F3_SLL, rd, rd));
            run(i_type({1'b0, v[k*11 +: 11]}, F3_OR, rd, rd));
        end
    endtask

    ////////////////////
    // Directed tests

    task automatic test_reset_state();
        xword_t d;
        resp_t r;
        for (int i = 0; i < NUM_REGS; i++) check_reg(reg_idx_t'(i));
        axi_read(ADDR_WIDTH'(256), d, r);    // Just past the register window
        check_word(d, '0, "out of window read");
        check_resp(r, SLVERR, "out of window read");
    endtask

    task automatic test_op();
        logic [9:0] ops [10];
        ops = '{{F7_BASE, F3_ADD}, {F7_ALT, F3_ADD}, {F7_BASE, F3_SLL}, {F7_BASE, F3_SLT},
                {F7_BASE, F3_SLTU}, {F7_BASE, F3_XOR}, {F7_BASE, F3_SR}, {F7_ALT, F3_SR},
                {F7_BASE, F3_OR}, {F7_BASE, F3_AND}};
        load_reg(1, rand_word());
        load_reg(2, rand_word());
        load_reg(3, rand_word() | {1'b1, 63'b0});    // Negative operand
        check_reg(3);
        foreach (ops[i]) begin
            run(r_type(ops[i][9:3], ops[i][2:0], 10, 1, 2));
            check_reg(10);
            run(r_type(ops[i][9:3], ops[i][2:0], 11, 3, 2));
            check_reg(11);
        end
    endtask

    task automatic test_op_imm();
        logic [11:0] imms [4];
        logic [2:0]  f3s [6];
        logic [5:0]  shamts [4];
        imms   = '{12'h7ff, 12'h800, 12'hfff, 12'h0};
        f3s    = '{F3_ADD, F3_SLT, F3_SLTU, F3_XOR, F3_OR, F3_AND};
        shamts = '{6'd0, 6'd31, 6'd32, 6'd63};
        imms[3] = 12'($random(seed));
        load_reg(4, rand_word() | {1'b1, 63'b0});
        foreach (f3s[i]) begin
            foreach (imms[j]) begin
                run(i_type(imms[j], f3s[i], 12, 4));
                check_reg(12);
            end
        end
        foreach (shamts[i]) begin
            run(i_type({F6_BASE, shamts[i]}, F3_SLL, 12, 4));
            check_reg(12);
            run(i_type({F6_BASE, shamts[i]}, F3_SR, 13, 4));
            check_reg(13);
            run(i_type({F6_ALT, shamts[i]}, F3_SR, 14, 4));
            check_reg(14);
        end
        run(i_type(12'hfff, F3_SLTU, 15, 0));    // Zero below all ones
        check_reg(15);
        run(lui(16, 20'hfedcb));
        check_reg(16);
    endtask

    // One write per cycle with bready high
    task automatic test_forwarding();
        instr_t prog [$];
        prog = '{i_type(12'hffd, F3_ADD, 5, 0), i_type({F6_BASE, 6'd4}, F3_SLL, 6, 5),
                 r_type(F7_BASE, F3_ADD, 7, 6, 5), r_type(F7_ALT, F3_ADD, 8, 7, 6),
                 r_type(F7_BASE, F3_XOR, 9, 8, 7)};
        foreach (prog[i]) begin
            @(posedge clk);
            awvalid <= 1'b1;
            wvalid  <= 1'b1;
            awaddr  <= ADDR_WIDTH'(ISSUE_ADDR);
            wdata   <= bus_word_t'(prog[i]);
            @(negedge clk);
            if (i > 0) check_resp(bresp, OKAY, "burst write");
            if (!awready || !wready) protocol_error("a back-to-back write was stalled");
            model_commit(prog[i]);
        end
        @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        @(negedge clk);
        check_resp(bresp, OKAY, "last burst write");
        for (int r = 5; r <= 9; r++) check_reg(reg_idx_t'(r));
    endtask

    task automatic test_illegal();
        run(i_type(12'd5, F3_ADD, 0, 0));
        run(r_type(F7_BASE, F3_ADD, 0, 1, 2));
        check_reg(0);
        expect_reject(ADDR_WIDTH'(ISSUE_ADDR), {25'h1abcd, 7'b0000011});    // Load opcode
        expect_reject(ADDR_WIDTH'(ISSUE_ADDR), r_type(7'b0000001, F3_ADD, 17, 1, 2));
        expect_reject(ADDR_WIDTH'(ISSUE_ADDR), r_type(F7_ALT, F3_XOR, 17, 1, 2));
        expect_reject(ADDR_WIDTH'(ISSUE_ADDR), i_type({6'b000001, 6'd3}, F3_SLL, 17, 1));
        expect_reject(ADDR_WIDTH'(8), i_type(12'd1, F3_ADD, 17, 0));
        for (int i = 0; i < NUM_REGS; i++) check_reg(reg_idx_t'(i));
    endtask

    task automatic test_backpressure();
        resp_t held_resp;
        xword_t held_data;
        @(posedge clk);
        bready  <= 1'b0;
        awvalid <= 1'b1;
        wvalid  <= 1'b1;
        awaddr  <= ADDR_WIDTH'(ISSUE_ADDR);
        wdata   <= bus_word_t'(i_type(12'd21, F3_ADD, 20, 0));
        @(posedge clk);                                    // First write taken
        wdata <= bus_word_t'(i_type(12'd1, F3_ADD, 20, 20));
        model_commit(i_type(12'd21, F3_ADD, 20, 0));
        @(negedge clk);
        held_resp = bresp;
        check_resp(bresp, OKAY, "held write");
        repeat (4) begin
            @(negedge clk);
            if (!bvalid || bresp !== held_resp) begin
                protocol_error("the write response changed while bready was low");
            end
            if (awready || wready) protocol_error("a second write was offered before the response");
        end
        @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);                                    // Second write taken
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        model_commit(i_type(12'd1, F3_ADD, 20, 20));
        @(negedge clk);
        check_resp(bresp, OKAY, "second write");
        @(posedge clk);
        rready  <= 1'b0;
        arvalid <= 1'b1;
        araddr  <= ADDR_WIDTH'(20) << REG_WINDOW_SHIFT;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        @(negedge clk);
        held_data = rdata;
        check_word(rdata, model_regs[20], "x20 under back-pressure");
        repeat (4) begin
            @(negedge clk);
            if (!rvalid || rdata !== held_data) begin
                protocol_error("the read data changed while rready was low");
            end
            if (arready) protocol_error("a second read was offered before the data");
        end
        @(posedge clk);
        rready <= 1'b1;
    endtask

    initial begin
        rst     = 1'b1;
        awvalid = 1'b0;
        awaddr  = '0;
        wvalid  = 1'b0;
        wdata   = '0;
        wstrb   = '1;
        bready  = 1'b1;
        arvalid = 1'b0;
        araddr  = '0;
        rready  = 1'b1;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset_state();
        test_op();
        test_op_imm();
        test_forwarding();
        test_illegal();
        test_backpressure();
        $display("Errors: %0d value, %0d response, %0d protocol",
                 value_errors, resp_errors, protocol_errors);
        if (value_errors + resp_errors + protocol_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
